// ==== src/fpsu_pkg.sv ====
package fpsu_pkg;

  // datapath geometry.
  localparam int DATA_W    = 64;
  localparam int LANE_W    = 32;
  localparam int NUM_LANES = DATA_W / LANE_W;

  // field widths.
  localparam int OP_W  = 4;
  localparam int TAG_W = 4;
  localparam int SEL_W = 3;

  // forwarding and queue sizing.
  localparam int NUM_FWD     = 4;
  localparam int ISSUE_DEPTH = 4;
  localparam int OUT_DEPTH   = 4;
  localparam int OUT_CREDITS = 4;

  localparam int ISSUE_AW = $clog2(ISSUE_DEPTH);
  localparam int OUT_AW   = $clog2(OUT_DEPTH);
  localparam int CRED_W   = $clog2(OUT_CREDITS) + 1;

  // opcodes, grouped by class in the upper bits.
  typedef enum logic [OP_W-1:0] {
    op_and   = 4'h0,
    op_or    = 4'h1,
    op_xor   = 4'h2,
    op_andn  = 4'h3,
    op_padd  = 4'h4,
    op_psub  = 4'h5,
    op_swap  = 4'h8,
    op_dupl  = 4'h9,
    op_duph  = 4'ha,
    op_merge = 4'hb
  } fpsu_op_e;

  // one word, or two lanes with lane 0 in the low half.
  typedef union packed {
    logic [DATA_W-1:0]                 word;
    logic [NUM_LANES-1:0][LANE_W-1:0]  lane;
  } fpsu_data_u;

  // sel 0 takes val, sel k takes forwarding bus k-1.
  typedef struct packed {
    logic [SEL_W-1:0] sel;
    fpsu_data_u       val;
  } fpsu_src_t;

  typedef struct packed {
    fpsu_op_e         op;
    logic [TAG_W-1:0] tag;
    fpsu_src_t        a;
    fpsu_src_t        b;
  } fpsu_issue_t;

  typedef struct packed {
    fpsu_op_e         op;
    logic [TAG_W-1:0] tag;
    fpsu_data_u       a;
    fpsu_data_u       b;
  } fpsu_exec_t;

  typedef struct packed {
    logic [TAG_W-1:0] tag;
    fpsu_data_u       data;
  } fpsu_result_t;

endpackage

// ==== src/operand_capture.sv ====
module operand_capture (
  input  logic                                            clk,
  input  logic                                            rst,
  input  logic                                            issue_valid,
  input  fpsu_pkg::fpsu_issue_t                           issue,
  input  fpsu_pkg::fpsu_data_u [fpsu_pkg::NUM_FWD-1:0]    fwd_bus,
  input  logic                                            alu_ready,
  output logic                                            issue_credit,
  output logic                                            exec_valid,
  output fpsu_pkg::fpsu_exec_t                            exec_pkt
);
  import fpsu_pkg::*;

  fpsu_exec_t          queue [ISSUE_DEPTH];
  logic [ISSUE_AW-1:0] wr_ptr;
  logic [ISSUE_AW-1:0] rd_ptr;
  logic [ISSUE_AW:0]   count;
  fpsu_exec_t          resolved;
  logic                push;
  logic                pop;

  // picks the operand's own value or one of the forwarding buses.
  function automatic fpsu_data_u resolve_src(
    input fpsu_src_t                  src,
    input fpsu_data_u [NUM_FWD-1:0]   bus
  );
    fpsu_data_u val;
    val = '0;
    if (src.sel == '0) begin
      val = src.val;
    end else begin
      for (int k = 0; k < NUM_FWD; k++) begin
        if (src.sel == SEL_W'(k + 1)) begin
          val = bus[k];
        end
      end
    end
    // selects past the last bus stay zero.
    return val;
  endfunction

  always_comb begin
    resolved.op  = issue.op;
    resolved.tag = issue.tag;
    resolved.a   = resolve_src(issue.a, fwd_bus);
    resolved.b   = resolve_src(issue.b, fwd_bus);
  end

  // issuer only sends while it holds a credit, so no full check here.
  assign push = issue_valid;
  assign pop  = (count != '0) && alu_ready;

  always_ff @(posedge clk) begin
    if (push) begin
      queue[wr_ptr] <= resolved;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
    end else if (push) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr <= '0;
    end else if (pop) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else begin
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign exec_valid = pop;
  assign exec_pkt   = queue[rd_ptr];

  // one credit back to the issuer for every entry that leaves.
  assign issue_credit = pop;

endmodule

// ==== src/simd_alu.sv ====
module simd_alu (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   exec_valid,
  input  fpsu_pkg::fpsu_exec_t   exec_pkt,
  output logic                   res_valid,
  output fpsu_pkg::fpsu_result_t res_pkt
);
  import fpsu_pkg::*;

  logic       is_logic;
  logic       is_arith;
  logic       is_perm;
  logic       is_sub;
  fpsu_data_u a;
  fpsu_data_u b;
  fpsu_data_u logic_res;
  fpsu_data_u arith_res;
  fpsu_data_u perm_res;
  fpsu_data_u result;

  assign a = exec_pkt.a;
  assign b = exec_pkt.b;

  // class decode.
  always_comb begin
    is_logic = 1'b0;
    is_arith = 1'b0;
    is_perm  = 1'b0;
    case (exec_pkt.op)
      op_and, op_or, op_xor, op_andn:        is_logic = 1'b1;
      op_padd, op_psub:                      is_arith = 1'b1;
      op_swap, op_dupl, op_duph, op_merge:   is_perm  = 1'b1;
      default: ;
    endcase
  end

  // whole-word logic.
  always_comb begin
    case (exec_pkt.op)
      op_and:  logic_res.word = a.word & b.word;
      op_or:   logic_res.word = a.word | b.word;
      op_xor:  logic_res.word = a.word ^ b.word;
      op_andn: logic_res.word = a.word & ~b.word;
      default: logic_res.word = '0;
    endcase
  end

  // lanes wrap on their own, no carry between them.
  assign is_sub = (exec_pkt.op == op_psub);

  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      if (is_sub) begin
        arith_res.lane[i] = a.lane[i] - b.lane[i];
      end else begin
        arith_res.lane[i] = a.lane[i] + b.lane[i];
      end
    end
  end

  always_comb begin
    perm_res.word = '0;
    case (exec_pkt.op)
      op_swap: begin
        perm_res.lane[1] = a.lane[0];
        perm_res.lane[0] = a.lane[1];
      end
      op_dupl: begin
        perm_res.lane[1] = a.lane[0];
        perm_res.lane[0] = a.lane[0];
      end
      op_duph: begin
        perm_res.lane[1] = a.lane[1];
        perm_res.lane[0] = a.lane[1];
      end
      op_merge: begin
        perm_res.lane[1] = a.lane[1];
        perm_res.lane[0] = b.lane[0];
      end
      default: ;
    endcase
  end

  always_comb begin
    result.word = '0;
    if (is_logic) result = logic_res;
    if (is_arith) result = arith_res;
    if (is_perm)  result = perm_res;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= exec_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (exec_valid) begin
      res_pkt.tag  <= exec_pkt.tag;
      res_pkt.data <= result;
    end
  end

endmodule

// ==== src/result_queue.sv ====
module result_queue (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   res_valid,
  input  fpsu_pkg::fpsu_result_t res_pkt,
  input  logic                   out_credit,
  output logic [2:0]             space,
  output logic                   out_valid,
  output fpsu_pkg::fpsu_result_t out
);
  import fpsu_pkg::*;

  fpsu_result_t      queue [OUT_DEPTH];
  logic [OUT_AW-1:0] wr_ptr;
  logic [OUT_AW-1:0] rd_ptr;
  logic [OUT_AW:0]   count;
  logic [CRED_W-1:0] credits;
  logic              push;
  logic              pop;

  // top level holds the ALU back before the queue can overflow.
  assign push = res_valid;
  assign pop  = (count != '0) && (credits != '0);

  always_ff @(posedge clk) begin
    if (push) begin
      queue[wr_ptr] <= res_pkt;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
    end else if (push) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr <= '0;
    end else if (pop) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else begin
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // a spend and a return in the same cycle cancel.
  always_ff @(posedge clk) begin
    if (rst) begin
      credits <= CRED_W'(OUT_CREDITS);
    end else begin
      case ({pop, out_credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  assign space     = 3'(OUT_DEPTH) - count;
  assign out_valid = pop;
  assign out       = queue[rd_ptr];

endmodule

// ==== src/fpsu_top.sv ====
module fpsu_top (
  input  logic                                          clk,
  input  logic                                          rst,
  input  logic                                          issue_valid,
  input  fpsu_pkg::fpsu_issue_t                         issue,
  input  fpsu_pkg::fpsu_data_u [fpsu_pkg::NUM_FWD-1:0]  fwd_bus,
  output logic                                          issue_credit,
  input  logic                                          out_credit,
  output logic                                          out_valid,
  output fpsu_pkg::fpsu_result_t                        out
);
  import fpsu_pkg::*;

  logic         alu_ready;
  logic         exec_valid;
  fpsu_exec_t   exec_pkt;
  logic         res_valid;
  fpsu_result_t res_pkt;
  logic [2:0]   space;

  // room for the result already in the ALU register plus the next one.
  assign alu_ready = (space > {2'b00, res_valid});

  operand_capture u_capture (
    .clk          (clk),
    .rst          (rst),
    .issue_valid  (issue_valid),
    .issue        (issue),
    .fwd_bus      (fwd_bus),
    .alu_ready    (alu_ready),
    .issue_credit (issue_credit),
    .exec_valid   (exec_valid),
    .exec_pkt     (exec_pkt)
  );

  simd_alu u_alu (
    .clk        (clk),
    .rst        (rst),
    .exec_valid (exec_valid),
    .exec_pkt   (exec_pkt),
    .res_valid  (res_valid),
    .res_pkt    (res_pkt)
  );

  result_queue u_result (
    .clk        (clk),
    .rst        (rst),
    .res_valid  (res_valid),
    .res_pkt    (res_pkt),
    .out_credit (out_credit),
    .space      (space),
    .out_valid  (out_valid),
    .out        (out)
  );

endmodule

// ==== testbench/tb_fpsu.sv ====
module tb_fpsu;
  timeunit 1ns;
  timeprecision 1ps;
  import fpsu_pkg::*;

  localparam int TIMEOUT     = 200;
  localparam int HOLD_CYCLES = 24;

  typedef struct {
    int                       test;
    fpsu_op_e                 op;
    logic [SEL_W-1:0]         sel_a;
    logic [SEL_W-1:0]         sel_b;
    logic [DATA_W-1:0]        a;
    logic [DATA_W-1:0]        b;
    fpsu_data_u [NUM_FWD-1:0] fwd;
    logic [DATA_W-1:0]        exp_word;
  } vec_t;

  logic                     clk;
  logic                     rst;
  logic                     issue_valid;
  fpsu_issue_t              issue;
  fpsu_data_u [NUM_FWD-1:0] fwd_bus;
  logic                     issue_credit;
  logic                     out_credit = 1'b0;
  logic                     out_valid;
  fpsu_result_t             out;

  vec_t         vectors[$];
  fpsu_result_t results[$];
  fpsu_op_e     op_list[10] = '{op_and, op_or, op_xor, op_andn, op_padd, op_psub,
                                op_swap, op_dupl, op_duph, op_merge};
  logic [31:0]  lfsr = 32'hb3aa_a4d8;
  logic [3:0]   next_tag = '0;
  logic         hold_credits = 1'b0;
  logic         timed_out = 1'b0;
  int           issued = 0;
  int           credit_pulses = 0;
  int           credit_violations = 0;
  int           credits_returned = 0;
  int           errors = 0;
  int           checks = 0;
  int           tests_run = 0;

  fpsu_top uut (
    .clk          (clk),
    .rst          (rst),
    .issue_valid  (issue_valid),
    .issue        (issue),
    .fwd_bus      (fwd_bus),
    .issue_credit (issue_credit),
    .out_credit   (out_credit),
    .out_valid    (out_valid),
    .out          (out)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // fibonacci lfsr with taps 32 22 2 1 and one step per bit.
  function automatic logic [DATA_W-1:0] rand_bits(input int nbits);
    logic [DATA_W-1:0] val;
    logic              fb;
    val = '0;
    for (int i = 0; i < nbits; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      val = {val[DATA_W-2:0], lfsr[0]};
    end
    return val;
  endfunction

  function automatic fpsu_op_e random_op();
    return op_list[rand_bits(4) % 10];
  endfunction

  function automatic logic [DATA_W-1:0] pick_operand(input logic [SEL_W-1:0] sel,
      input logic [DATA_W-1:0] own, input fpsu_data_u [NUM_FWD-1:0] fwd);
    if (sel == '0) return own;
    if (sel <= NUM_FWD) return fwd[sel - 1].word;
    return '0;
  endfunction

  // reference model with the lanes as 32-bit halves.
  function automatic logic [DATA_W-1:0] ref_result(input fpsu_op_e op,
      input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
    logic [31:0] a_hi;
    logic [31:0] a_lo;
    logic [31:0] b_hi;
    logic [31:0] b_lo;
    a_hi = a[63:32];
    a_lo = a[31:0];
    b_hi = b[63:32];
    b_lo = b[31:0];
    case (op)
      op_and:   return a & b;
      op_or:    return a | b;
      op_xor:   return a ^ b;
      op_andn:  return a & ~b;
      op_padd:  return {a_hi + b_hi, a_lo + b_lo};
      op_psub:  return {a_hi - b_hi, a_lo - b_lo};
      op_swap:  return {a_lo, a_hi};
      op_dupl:  return {a_lo, a_lo};
      op_duph:  return {a_hi, a_hi};
      op_merge: return {a_hi, b_lo};
      default:  return '0;
    endcase
  endfunction

  task automatic add_fixed(input int test, input fpsu_op_e op, input logic [DATA_W-1:0] a,
      input logic [DATA_W-1:0] b, input logic [DATA_W-1:0] exp_word);
    vec_t v;
    v.test = test;
    v.op = op;
    v.sel_a = '0;
    v.sel_b = '0;
    v.a = a;
    v.b = b;
    v.fwd = '0;
    v.exp_word = exp_word;
    vectors.push_back(v);
  endtask

  task automatic add_random(input int test, input fpsu_op_e op,
      input logic [SEL_W-1:0] sel_a, input logic [SEL_W-1:0] sel_b);
    vec_t v;
    v.test = test;
    v.op = op;
    v.sel_a = sel_a;
    v.sel_b = sel_b;
    v.a = rand_bits(DATA_W);
    v.b = rand_bits(DATA_W);
    for (int k = 0; k < NUM_FWD; k++) v.fwd[k].word = rand_bits(DATA_W);
    v.exp_word = ref_result(v.op, pick_operand(sel_a, v.a, v.fwd),
                            pick_operand(sel_b, v.b, v.fwd));
    vectors.push_back(v);
  endtask

  task automatic build_vectors();
    add_fixed(0, op_and, 64'hf0f0_ff00_ffff_fff0, 64'h0ff0_0f0f_0000_0020, 64'h00f0_0f00_0000_0020);
    add_fixed(0, op_or, 64'hf0f0_ff00_ffff_fff0, 64'h0ff0_0f0f_0000_0020, 64'hfff0_ff0f_ffff_fff0);
    add_fixed(0, op_xor, 64'hf0f0_ff00_ffff_fff0, 64'h0ff0_0f0f_0000_0020, 64'hff00_f00f_ffff_ffd0);
    add_fixed(0, op_andn, 64'hf0f0_ff00_ffff_fff0, 64'h0ff0_0f0f_0000_0020, 64'hf000_f000_ffff_ffd0);
    // lane 0 wraps while lane 1 must not see the carry or borrow.
    add_fixed(1, op_padd, 64'h0000_0001_ffff_fff0, 64'h0000_0002_0000_0020, 64'h0000_0003_0000_0010);
    add_fixed(1, op_psub, 64'h0000_0005_0000_0010, 64'h0000_0001_0000_0020, 64'h0000_0004_ffff_fff0);
    add_fixed(2, op_swap, 64'h1111_2222_3333_4444, 64'h5555_6666_7777_8888, 64'h3333_4444_1111_2222);
    add_fixed(2, op_dupl, 64'h1111_2222_3333_4444, 64'h5555_6666_7777_8888, 64'h3333_4444_3333_4444);
    add_fixed(2, op_duph, 64'h1111_2222_3333_4444, 64'h5555_6666_7777_8888, 64'h1111_2222_1111_2222);
    add_fixed(2, op_merge, 64'h1111_2222_3333_4444, 64'h5555_6666_7777_8888, 64'h1111_2222_7777_8888);
    add_fixed(2, fpsu_op_e'(4'hf), 64'h1111_2222_3333_4444, 64'h5555_6666_7777_8888, 64'h0);
    // every bus is taken at least once on the a side.
    for (int i = 0; i < 6; i++) begin
      add_random(3, random_op(), SEL_W'(1 + i % 4), SEL_W'(1 + rand_bits(2)));
    end
    add_random(3, op_or, 3'd5, 3'd0);
    add_random(3, op_xor, SEL_W'(1 + rand_bits(2)), 3'd5);
    for (int i = 0; i < 10; i++) add_random(4, random_op(), 3'd0, 3'd0);
  endtask

  task automatic check_result(input fpsu_result_t got, input fpsu_result_t exp,
      input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t ns %s: got tag %0d data %h, expected tag %0d data %h",
               $time, what, got.tag, got.data.word, exp.tag, exp.data.word);
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    checks++;
    if (got != exp) begin
      errors++;
      $display("ERR %0t ns %s: got %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    timed_out = 1'b1;
    $display("timeout at %0t ns: gave up waiting for %s", $time, what);
  endtask

  task automatic report_test(input string name, input int err_before);
    tests_run++;
    $display("test %s: %s", name, (errors == err_before) ? "ok" : "had errors");
  endtask

  // waits for an issue credit before driving one operation.
  task automatic issue_vector(input vec_t v);
    fpsu_issue_t pkt;
    int          waited;
    waited = 0;
    if (timed_out) return;
    @(posedge clk);
    while (ISSUE_DEPTH - issued + credit_pulses <= 0 && waited < TIMEOUT) begin
      issue_valid <= 1'b0;
      @(posedge clk);
      waited++;
    end
    if (ISSUE_DEPTH - issued + credit_pulses <= 0) begin
      report_timeout("an issue credit");
      return;
    end
    pkt.op = v.op;
    pkt.tag = next_tag;
    pkt.a.sel = v.sel_a;
    pkt.a.val.word = v.a;
    pkt.b.sel = v.sel_b;
    pkt.b.val.word = v.b;
    issue_valid <= 1'b1;
    issue <= pkt;
    fwd_bus <= v.fwd;
    next_tag = next_tag + 1'b1;
    issued++;
  endtask

  task automatic wait_results(input int target, input string what);
    int waited;
    waited = 0;
    while (results.size() < target && waited < TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    if (results.size() < target) report_timeout(what);
  endtask

  task automatic run_test(input int id, input string name, input bit hold);
    int           idx[$];
    int           base;
    int           err_before;
    logic [3:0]   base_tag;
    fpsu_result_t exp;
    err_before = errors;
    if (timed_out) return;
    foreach (vectors[i]) begin
      if (vectors[i].test == id) idx.push_back(i);
    end
    base = results.size();
    base_tag = next_tag;
    @(negedge clk);
    hold_credits = hold;
    foreach (idx[k]) issue_vector(vectors[idx[k]]);
    @(posedge clk);
    issue_valid <= 1'b0;
    if (hold) begin
      wait_results(base + OUT_CREDITS, "results of the burst");
      repeat (HOLD_CYCLES) @(posedge clk);
      check_count(results.size() - base, OUT_CREDITS, "results before credit return");
      @(negedge clk);
      hold_credits = 1'b0;
    end
    wait_results(base + idx.size(), name);
    if (!timed_out) begin
      foreach (idx[k]) begin
        exp.tag = base_tag + 4'(k);
        exp.data.word = vectors[idx[k]].exp_word;
        check_result(results[base + k], exp, name);
      end
    end
    report_test(name, err_before);
  endtask

  task automatic check_credit_return();
    int err_before;
    int waited;
    err_before = errors;
    waited = 0;
    while ((credit_pulses < issued || credits_returned < results.size()) &&
           waited < TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    check_count(credit_pulses, issued, "issue credits returned");
    check_count(credit_violations, 0, "credits beyond issues");
    check_count(results.size(), issued, "results delivered");
    report_test("credit return", err_before);
  endtask

  // monitor samples on the falling edge.
  always @(negedge clk) begin
    if (!rst) begin
      if (out_valid) results.push_back(out);
      if (issue_credit) credit_pulses++;
      if (credit_pulses > issued) credit_violations++;
    end
  end

  // consumer returns one credit per received result unless holding.
  always @(posedge clk) begin
    if (!rst && !hold_credits && credits_returned < results.size()) begin
      out_credit <= 1'b1;
      credits_returned <= credits_returned + 1;
    end else begin
      out_credit <= 1'b0;
    end
  end

  initial begin
    rst = 1'b1;
    issue_valid = 1'b0;
    issue = '0;
    fwd_bus = '0;
    build_vectors();
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    run_test(0, "logic ops", 1'b0);
    run_test(1, "lane arithmetic", 1'b0);
    run_test(2, "permutes", 1'b0);
    run_test(3, "forwarding", 1'b0);
    run_test(4, "back-pressure", 1'b1);
    check_credit_return();
    $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
src/fpsu_pkg.sv
src/operand_capture.sv
src/simd_alu.sv
src/result_queue.sv
src/fpsu_top.sv
testbench/tb_fpsu.sv
